// ==== hw/lcd_cmd_pkg.sv ====
package lcd_cmd_pkg;

  // panel command opcodes, a small subset of the DCS command set
  typedef enum logic [7:0] {
    sw_reset     = 8'h01,
    sleep_out    = 8'h11,
    display_on   = 8'h29,
    column_set   = 8'h2A,
    page_set     = 8'h2B,
    memory_write = 8'h2C
  } lcd_opcode_e;

  // level of the dcx line
  // low marks an opcode byte, high marks a parameter or pixel byte
  localparam logic dcx_command = 1'b0;
  localparam logic dcx_data    = 1'b1;

  // sequencer states
  // the first five run once after reset, the rest once per rectangle
  typedef enum logic [3:0] {
    power_wait,
    send_reset,
    reset_wait,
    send_sleep_out,
    send_display_on,
    idle,
    send_window,
    send_ram_write,
    send_pixels
  } seq_state_e;

endpackage

// ==== hw/lcd_geom_pkg.sv ====
package lcd_geom_pkg;

  // panel size in pixels, portrait orientation
  localparam int screen_width  = 240;
  localparam int screen_height = 320;

  // a coordinate fits in 10 bits
  // so the high byte on the bus only ever carries two bits
  localparam int coord_width = 10;

  // RGB565 colour, sent high byte first
  localparam int colour_width = 16;

  // full screen is 76800 pixels, needs 17 bits
  localparam int pixel_count_width = 17;

  // hwclk cycles per bus tick
  // one write takes three ticks plus one acceptance cycle
  localparam int tick_div = 2;

  // delay before the first command, counted in ticks
  localparam int power_wait_ticks = 30;

  // delay after software reset before sleep-out, in ticks
  localparam int reset_wait_ticks = 36;

endpackage

// ==== hw/lcd_tick_gen.sv ====
module lcd_tick_gen (
  input  logic hwclk,
  input  logic reset,
  output logic tick
);

  // one bit is enough even when the divider is one
  localparam int cnt_width =
    (lcd_geom_pkg::tick_div > 1) ? $clog2(lcd_geom_pkg::tick_div) : 1;
  localparam logic [cnt_width-1:0] cnt_last = cnt_width'(lcd_geom_pkg::tick_div - 1);

  logic [cnt_width-1:0] cnt;

  // free running divider, tick is registered so it is a clean single pulse
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == cnt_last) begin
      cnt  <= '0;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// ==== hw/lcd_bus_writer.sv ====
module lcd_bus_writer (
  input  logic       hwclk,
  input  logic       reset,
  input  logic       tick,
  input  logic       wr_req,
  input  logic       wr_dcx,
  input  logic [7:0] wr_data,
  output logic       busy,
  output logic       done,
  output logic       csx,
  output logic       dcx,
  output logic       wrx,
  output logic [7:0] data
);

  // phases of one 8080 write cycle
  typedef enum logic [1:0] {
    ph_idle,
    ph_select,
    ph_strobe,
    ph_hold
  } phase_e;

  phase_e phase;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      phase <= ph_idle;
      busy  <= 1'b0;
      done  <= 1'b0;
      csx   <= 1'b1;
      wrx   <= 1'b1;
      dcx   <= lcd_cmd_pkg::dcx_command;
      data  <= 8'h00;
    end else begin
      // done is only ever a single cycle
      done <= 1'b0;
      case (phase)
        ph_idle: begin
          // select the panel and put the byte out right away
          if (wr_req) begin
            csx   <= 1'b0;
            dcx   <= wr_dcx;
            data  <= wr_data;
            busy  <= 1'b1;
            phase <= ph_select;
          end
        end
        ph_select: begin
          // setup time is one tick before the strobe falls
          if (tick) begin
            wrx   <= 1'b0;
            phase <= ph_strobe;
          end
        end
        ph_strobe: begin
          // panel latches dcx and data on this rising edge
          if (tick) begin
            wrx   <= 1'b1;
            phase <= ph_hold;
          end
        end
        ph_hold: begin
          // hold one more tick, then release the chip select
          if (tick) begin
            csx   <= 1'b1;
            busy  <= 1'b0;
            done  <= 1'b1;
            phase <= ph_idle;
          end
        end
        default: phase <= ph_idle;
      endcase
    end
  end

  // the sequencer must wait for done before it asks again
  a_no_req_while_busy: assert property (
    @(posedge hwclk) disable iff (reset) wr_req |-> !busy);

  // dcx and data must not move while the strobe is low
  a_bus_stable_in_strobe: assert property (
    @(posedge hwclk) disable iff (reset) !wrx |-> $stable(data) && $stable(dcx));

endmodule

// ==== hw/lcd_pixel_source.sv ====
module lcd_pixel_source (
  input  logic                                  hwclk,
  input  logic                                  reset,
  input  logic                                  fill_start,
  input  logic                                  px_next,
  input  logic [lcd_geom_pkg::coord_width-1:0]  fill_x0,
  input  logic [lcd_geom_pkg::coord_width-1:0]  fill_x1,
  input  logic [lcd_geom_pkg::coord_width-1:0]  fill_y0,
  input  logic [lcd_geom_pkg::coord_width-1:0]  fill_y1,
  input  logic [lcd_geom_pkg::colour_width-1:0] fill_colour,
  output logic [7:0]                            px_byte,
  output logic                                  px_last
);

  // spans carry one extra bit so a full-width span does not wrap
  logic [lcd_geom_pkg::coord_width:0]             span_x;
  logic [lcd_geom_pkg::coord_width:0]             span_y;
  logic [2*lcd_geom_pkg::coord_width+1:0]         area;
  logic [lcd_geom_pkg::pixel_count_width-1:0]     remaining;
  logic                                           low_phase;
  logic [lcd_geom_pkg::colour_width-1:0]          colour_q;

  // the sequencer only passes rectangles with x0 <= x1 and y0 <= y1
  always_comb begin
    span_x = {1'b0, fill_x1} - {1'b0, fill_x0} + 1'b1;
    span_y = {1'b0, fill_y1} - {1'b0, fill_y0} + 1'b1;
    area   = span_x * span_y;
  end

  // pixel counter and byte phase
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      remaining <= '0;
      low_phase <= 1'b0;
    end else if (fill_start) begin
      remaining <= area[lcd_geom_pkg::pixel_count_width-1:0];
      low_phase <= 1'b0;
    end else if (px_next) begin
      // a pixel is used up once its low byte has gone
      if (low_phase) begin
        remaining <= remaining - 1'b1;
      end
      low_phase <= !low_phase;
    end
  end

  // colour stays fixed for the whole rectangle
  always_ff @(posedge hwclk) begin
    if (fill_start) begin
      colour_q <= fill_colour;
    end
  end

  // high byte first, then low byte
  assign px_byte = low_phase ? colour_q[7:0] : colour_q[lcd_geom_pkg::colour_width-1 -: 8];
  assign px_last = low_phase && (remaining == lcd_geom_pkg::pixel_count_width'(1));

endmodule

// ==== hw/lcd_sequencer.sv ====
module lcd_sequencer (
  input  logic                                  hwclk,
  input  logic                                  reset,
  input  logic                                  tick,
  input  logic                                  draw,
  input  logic [lcd_geom_pkg::coord_width-1:0]  x0,
  input  logic [lcd_geom_pkg::coord_width-1:0]  x1,
  input  logic [lcd_geom_pkg::coord_width-1:0]  y0,
  input  logic [lcd_geom_pkg::coord_width-1:0]  y1,
  input  logic [lcd_geom_pkg::colour_width-1:0] colour,
  input  logic                                  done,
  input  logic [7:0]                            px_byte,
  input  logic                                  px_last,
  output logic                                  ready,
  output logic                                  wr_req,
  output logic                                  wr_dcx,
  output logic [7:0]                            wr_data,
  output logic                                  fill_start,
  output logic                                  px_next,
  output logic [lcd_geom_pkg::coord_width-1:0]  fill_x0,
  output logic [lcd_geom_pkg::coord_width-1:0]  fill_x1,
  output logic [lcd_geom_pkg::coord_width-1:0]  fill_y0,
  output logic [lcd_geom_pkg::coord_width-1:0]  fill_y1,
  output logic [lcd_geom_pkg::colour_width-1:0] fill_colour
);

  // delay counter sized for the longer of the two waits
  localparam int delay_max = (lcd_geom_pkg::power_wait_ticks > lcd_geom_pkg::reset_wait_ticks) ?
    lcd_geom_pkg::power_wait_ticks : lcd_geom_pkg::reset_wait_ticks;
  localparam int delay_width = $clog2(delay_max + 1);
  localparam logic [delay_width-1:0] power_last =
    delay_width'(lcd_geom_pkg::power_wait_ticks - 1);
  localparam logic [delay_width-1:0] reset_last =
    delay_width'(lcd_geom_pkg::reset_wait_ticks - 1);
  // column cmd, 4 bytes, page cmd, 4 bytes
  localparam logic [3:0] window_last = 4'd9;

  lcd_cmd_pkg::seq_state_e state;
  logic [delay_width-1:0]  delay_cnt;
  logic [3:0]              byte_idx;
  logic                    pending;
  logic                    sending;
  logic                    draw_ok;
  logic                    draw_accept;
  logic                    cur_dcx;
  logic [7:0]              cur_byte;
  logic [15:0]             x0_word;
  logic [15:0]             x1_word;
  logic [15:0]             y0_word;
  logic [15:0]             y1_word;

  // window coordinates go out as 16-bit big-endian values
  assign x0_word = 16'(fill_x0);
  assign x1_word = 16'(fill_x1);
  assign y0_word = 16'(fill_y0);
  assign y1_word = 16'(fill_y1);

  // on screen and not inverted
  assign draw_ok = (x1 < lcd_geom_pkg::screen_width) && (y1 < lcd_geom_pkg::screen_height) &&
                   (x0 <= x1) && (y0 <= y1);
  assign draw_accept = (state == lcd_cmd_pkg::idle) && ready && draw && draw_ok;

  assign sending = state inside {lcd_cmd_pkg::send_reset, lcd_cmd_pkg::send_sleep_out,
                                 lcd_cmd_pkg::send_display_on, lcd_cmd_pkg::send_window,
                                 lcd_cmd_pkg::send_ram_write, lcd_cmd_pkg::send_pixels};

  // pixel source loads and steps on the same edge as done
  // so px_byte is already current when the next request is built
  assign fill_start = (state == lcd_cmd_pkg::send_ram_write) && done;
  assign px_next    = (state == lcd_cmd_pkg::send_pixels) && done;

  // byte for the current state
  always_comb begin
    cur_dcx  = lcd_cmd_pkg::dcx_command;
    cur_byte = 8'h00;
    case (state)
      lcd_cmd_pkg::send_reset:      cur_byte = lcd_cmd_pkg::sw_reset;
      lcd_cmd_pkg::send_sleep_out:  cur_byte = lcd_cmd_pkg::sleep_out;
      lcd_cmd_pkg::send_display_on: cur_byte = lcd_cmd_pkg::display_on;
      lcd_cmd_pkg::send_window: begin
        cur_dcx = lcd_cmd_pkg::dcx_data;
        case (byte_idx)
          4'd0: begin
            cur_dcx  = lcd_cmd_pkg::dcx_command;
            cur_byte = lcd_cmd_pkg::column_set;
          end
          4'd1: cur_byte = x0_word[15:8];
          4'd2: cur_byte = x0_word[7:0];
          4'd3: cur_byte = x1_word[15:8];
          4'd4: cur_byte = x1_word[7:0];
          4'd5: begin
            cur_dcx  = lcd_cmd_pkg::dcx_command;
            cur_byte = lcd_cmd_pkg::page_set;
          end
          4'd6: cur_byte = y0_word[15:8];
          4'd7: cur_byte = y0_word[7:0];
          4'd8: cur_byte = y1_word[15:8];
          default: cur_byte = y1_word[7:0];
        endcase
      end
      lcd_cmd_pkg::send_ram_write:  cur_byte = lcd_cmd_pkg::memory_write;
      lcd_cmd_pkg::send_pixels: begin
        cur_dcx  = lcd_cmd_pkg::dcx_data;
        cur_byte = px_byte;
      end
      default: cur_byte = 8'h00;
    endcase
  end

  // control state
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state     <= lcd_cmd_pkg::power_wait;
      delay_cnt <= '0;
      byte_idx  <= '0;
      pending   <= 1'b0;
      wr_req    <= 1'b0;
      ready     <= 1'b0;
    end else begin
      wr_req <= 1'b0;
      // one request per byte, then wait for the writer to finish it
      if (sending && !pending) begin
        wr_req  <= 1'b1;
        pending <= 1'b1;
      end
      if (done) begin
        pending <= 1'b0;
      end
      case (state)
        lcd_cmd_pkg::power_wait: begin
          if (tick) begin
            if (delay_cnt == power_last) begin
              delay_cnt <= '0;
              state     <= lcd_cmd_pkg::send_reset;
            end else begin
              delay_cnt <= delay_cnt + 1'b1;
            end
          end
        end
        lcd_cmd_pkg::send_reset: begin
          if (done) state <= lcd_cmd_pkg::reset_wait;
        end
        lcd_cmd_pkg::reset_wait: begin
          // panel needs time to come out of its own reset
          if (tick) begin
            if (delay_cnt == reset_last) begin
              delay_cnt <= '0;
              state     <= lcd_cmd_pkg::send_sleep_out;
            end else begin
              delay_cnt <= delay_cnt + 1'b1;
            end
          end
        end
        lcd_cmd_pkg::send_sleep_out: begin
          if (done) state <= lcd_cmd_pkg::send_display_on;
        end
        lcd_cmd_pkg::send_display_on: begin
          if (done) begin
            state <= lcd_cmd_pkg::idle;
            ready <= 1'b1;
          end
        end
        lcd_cmd_pkg::idle: begin
          // rejected draws fall through, ready stays up
          if (draw_accept) begin
            ready    <= 1'b0;
            byte_idx <= '0;
            state    <= lcd_cmd_pkg::send_window;
          end
        end
        lcd_cmd_pkg::send_window: begin
          if (done) begin
            if (byte_idx == window_last) begin
              state <= lcd_cmd_pkg::send_ram_write;
            end else begin
              byte_idx <= byte_idx + 1'b1;
            end
          end
        end
        lcd_cmd_pkg::send_ram_write: begin
          if (done) state <= lcd_cmd_pkg::send_pixels;
        end
        lcd_cmd_pkg::send_pixels: begin
          // px_last still refers to the byte that just finished
          if (done && px_last) begin
            state <= lcd_cmd_pkg::idle;
            ready <= 1'b1;
          end
        end
        default: state <= lcd_cmd_pkg::power_wait;
      endcase
    end
  end

  // request payload and latched rectangle
  always_ff @(posedge hwclk) begin
    if (sending && !pending) begin
      wr_dcx  <= cur_dcx;
      wr_data <= cur_byte;
    end
    if (draw_accept) begin
      fill_x0     <= x0;
      fill_x1     <= x1;
      fill_y0     <= y0;
      fill_y1     <= y1;
      fill_colour <= colour;
    end
  end

  // pixel steps only for a byte that is actually in flight
  a_px_next_in_pixels: assert property (
    @(posedge hwclk) disable iff (reset)
    px_next |-> (state == lcd_cmd_pkg::send_pixels) && pending);

endmodule

// ==== hw/lcd_display_top.sv ====
module lcd_display_top (
  input  logic                                  hwclk,
  input  logic                                  reset,
  input  logic                                  draw,
  input  logic [lcd_geom_pkg::coord_width-1:0]  x0,
  input  logic [lcd_geom_pkg::coord_width-1:0]  x1,
  input  logic [lcd_geom_pkg::coord_width-1:0]  y0,
  input  logic [lcd_geom_pkg::coord_width-1:0]  y1,
  input  logic [lcd_geom_pkg::colour_width-1:0] colour,
  output logic                                  ready,
  output logic                                  lcd_csx,
  output logic                                  lcd_dcx,
  output logic                                  lcd_wrx,
  output logic [7:0]                            lcd_data
);

  logic                                  tick;
  logic                                  wr_req;
  logic                                  wr_dcx;
  logic [7:0]                            wr_data;
  logic                                  done;
  logic                                  fill_start;
  logic                                  px_next;
  logic [lcd_geom_pkg::coord_width-1:0]  fill_x0;
  logic [lcd_geom_pkg::coord_width-1:0]  fill_x1;
  logic [lcd_geom_pkg::coord_width-1:0]  fill_y0;
  logic [lcd_geom_pkg::coord_width-1:0]  fill_y1;
  logic [lcd_geom_pkg::colour_width-1:0] fill_colour;
  logic [7:0]                            px_byte;
  logic                                  px_last;

  // bus pacing, everything stays on hwclk
  lcd_tick_gen i_tick_gen (.hwclk(hwclk), .reset(reset), .tick(tick));

  lcd_sequencer i_sequencer (
    .hwclk(hwclk), .reset(reset), .tick(tick), .draw(draw),
    .x0(x0), .x1(x1), .y0(y0), .y1(y1), .colour(colour),
    .done(done), .px_byte(px_byte), .px_last(px_last),
    .ready(ready), .wr_req(wr_req), .wr_dcx(wr_dcx), .wr_data(wr_data),
    .fill_start(fill_start), .px_next(px_next),
    .fill_x0(fill_x0), .fill_x1(fill_x1), .fill_y0(fill_y0), .fill_y1(fill_y1),
    .fill_colour(fill_colour)
  );

  lcd_pixel_source i_pixel_source (
    .hwclk(hwclk), .reset(reset), .fill_start(fill_start), .px_next(px_next),
    .fill_x0(fill_x0), .fill_x1(fill_x1), .fill_y0(fill_y0), .fill_y1(fill_y1),
    .fill_colour(fill_colour), .px_byte(px_byte), .px_last(px_last)
  );

  // sequencer paces itself on done, busy is only checked inside the writer
  lcd_bus_writer i_bus_writer (
    .hwclk(hwclk), .reset(reset), .tick(tick),
    .wr_req(wr_req), .wr_dcx(wr_dcx), .wr_data(wr_data),
    .busy(), .done(done),
    .csx(lcd_csx), .dcx(lcd_dcx), .wrx(lcd_wrx), .data(lcd_data)
  );

endmodule

// ==== testbench/lcd_bus_monitor.sv ====
module lcd_bus_monitor (
  input logic       csx,
  input logic       dcx,
  input logic       wrx,
  input logic [7:0] data
);
  timeunit 1ns;
  timeprecision 1ps;

  // captured bus bytes, dcx flag in bit 8 and data below it
  logic [8:0] captured[$];

  // strobes or selects seen out of order on the panel pins
  int protocol_errors = 0;

  // panel latches dcx and data on the rising edge of the write strobe
  // the x to 1 edge at reset is skipped since csx is not low then
  always @(posedge wrx) begin
    if (csx === 1'b0) begin
      captured.push_back({dcx, data});
    end
  end

  // a strobe outside chip select would never reach the panel
  always @(negedge wrx) begin
    assert (csx === 1'b0) else begin
      $display("bus protocol error at %0t: write strobe fell while chip select was high",
               $time);
      protocol_errors++;
    end
  end

  // chip select has to stay low until the strobe is back up
  always @(posedge csx) begin
    assert (wrx !== 1'b0) else begin
      $display("bus protocol error at %0t: chip select rose while write strobe was low",
               $time);
      protocol_errors++;
    end
  end

endmodule

// ==== testbench/tb_lcd_display.sv ====
module tb_lcd_display;
  timeunit 1ns;
  timeprecision 1ps;

  // one row of the draw table
  typedef struct packed {
    logic [lcd_geom_pkg::coord_width-1:0]  x0;
    logic [lcd_geom_pkg::coord_width-1:0]  x1;
    logic [lcd_geom_pkg::coord_width-1:0]  y0;
    logic [lcd_geom_pkg::coord_width-1:0]  y1;
    logic [lcd_geom_pkg::colour_width-1:0] colour;
    logic                                  rand_colour;
    logic                                  accept;
    logic                                  poke;
  } draw_entry_t;

  logic                                  hwclk;
  logic                                  reset;
  logic                                  draw;
  logic [lcd_geom_pkg::coord_width-1:0]  x0;
  logic [lcd_geom_pkg::coord_width-1:0]  x1;
  logic [lcd_geom_pkg::coord_width-1:0]  y0;
  logic [lcd_geom_pkg::coord_width-1:0]  y1;
  logic [lcd_geom_pkg::colour_width-1:0] colour;
  logic                                  ready;
  logic                                  lcd_csx;
  logic                                  lcd_dcx;
  logic                                  lcd_wrx;
  logic [7:0]                            lcd_data;

  draw_entry_t draws[$];
  logic [8:0]  expected[$];
  logic [31:0] rng_state;
  int          mismatches;
  int          failures;
  bit          aborted;

  lcd_display_top i_dut (
    .hwclk(hwclk), .reset(reset), .draw(draw),
    .x0(x0), .x1(x1), .y0(y0), .y1(y1), .colour(colour),
    .ready(ready), .lcd_csx(lcd_csx), .lcd_dcx(lcd_dcx), .lcd_wrx(lcd_wrx),
    .lcd_data(lcd_data)
  );

  lcd_bus_monitor i_monitor (.csx(lcd_csx), .dcx(lcd_dcx), .wrx(lcd_wrx), .data(lcd_data));

  // 10 ns hwclk
  always #5 hwclk = ~hwclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic add_draw(input int ax0, input int ax1, input int ay0, input int ay1,
                          input logic [15:0] c, input bit rnd, input bit acc, input bit pk);
    draw_entry_t e;
    e = '{x0: ax0, x1: ax1, y0: ay0, y1: ay1, colour: c, rand_colour: rnd, accept: acc,
          poke: pk};
    draws.push_back(e);
  endtask

  task automatic load_table();
    // single pixel with a fixed colour
    add_draw(5, 5, 7, 7, 16'hF81F, 0, 1, 0);
    add_draw(10, 12, 20, 21, 16'h0000, 1, 1, 0);
    // stray strobe lands while this one is being drawn
    add_draw(100, 103, 200, 202, 16'h0000, 1, 1, 1);
    // y above 255 puts a one in the high byte
    add_draw(0, 1, 300, 319, 16'h0000, 1, 1, 0);
    // inverted x, off screen x, off screen y, inverted y
    add_draw(50, 40, 0, 0, 16'h1234, 0, 0, 0);
    add_draw(230, 240, 0, 0, 16'h1234, 0, 0, 0);
    add_draw(0, 0, 310, 320, 16'h1234, 0, 0, 0);
    add_draw(0, 0, 10, 5, 16'h1234, 0, 0, 0);
    // bottom right corner
    add_draw(236, 239, 316, 319, 16'h0000, 1, 1, 0);
  endtask

  task automatic expect_byte(input logic flag, input logic [7:0] value);
    expected.push_back({flag, value});
  endtask

  // coordinates leave as 16-bit big-endian words
  task automatic expect_coord(input logic [lcd_geom_pkg::coord_width-1:0] c);
    expect_byte(lcd_cmd_pkg::dcx_data, 8'(int'(c) / 256));
    expect_byte(lcd_cmd_pkg::dcx_data, 8'(int'(c) % 256));
  endtask

  task automatic build_rect_bytes(input draw_entry_t e);
    int pixels;
    pixels = (int'(e.x1) - int'(e.x0) + 1) * (int'(e.y1) - int'(e.y0) + 1);
    expect_byte(lcd_cmd_pkg::dcx_command, lcd_cmd_pkg::column_set);
    expect_coord(e.x0);
    expect_coord(e.x1);
    expect_byte(lcd_cmd_pkg::dcx_command, lcd_cmd_pkg::page_set);
    expect_coord(e.y0);
    expect_coord(e.y1);
    expect_byte(lcd_cmd_pkg::dcx_command, lcd_cmd_pkg::memory_write);
    // high byte then low byte, once per pixel
    for (int p = 0; p < pixels; p++) begin
      expect_byte(lcd_cmd_pkg::dcx_data, e.colour[15:8]);
      expect_byte(lcd_cmd_pkg::dcx_data, e.colour[7:0]);
    end
  endtask

  // inputs change on the rising edge, draw is high for one cycle
  task automatic pulse_draw(input draw_entry_t e);
    @(posedge hwclk);
    draw   <= 1'b1;
    x0     <= e.x0;
    x1     <= e.x1;
    y0     <= e.y0;
    y1     <= e.y1;
    colour <= e.colour;
    @(posedge hwclk);
    draw   <= 1'b0;
  endtask

  // ready is sampled on the falling edge, away from the DUT's updates
  task automatic wait_ready(input logic level, input int limit, input string what);
    int n;
    n = 0;
    @(negedge hwclk);
    while (ready !== level && n < limit) begin
      @(negedge hwclk);
      n++;
    end
    assert (ready === level) else begin
      $display("timeout: ready did not go to %0d %s within %0d cycles", level, what, limit);
      failures++;
      aborted = 1;
    end
  endtask

  task automatic compare_stream(input string what);
    logic [8:0] got;
    logic [8:0] exp;
    int         n;
    n = 0;
    assert (i_monitor.captured.size() == expected.size()) else begin
      $display("%s: bus carried %0d bytes but %0d were expected", what,
               i_monitor.captured.size(), expected.size());
      failures++;
    end
    while (i_monitor.captured.size() > 0 && expected.size() > 0) begin
      got = i_monitor.captured.pop_front();
      exp = expected.pop_front();
      assert (got[8] == exp[8]) else begin
        $display("MISMATCH at %0t: lcd_dcx byte %0d of %s expected %0b got %0b",
                 $time, n, what, exp[8], got[8]);
        mismatches++;
      end
      assert (got[7:0] == exp[7:0]) else begin
        $display("MISMATCH at %0t: lcd_data byte %0d of %s expected %02h got %02h",
                 $time, n, what, exp[7:0], got[7:0]);
        mismatches++;
      end
      n++;
    end
    i_monitor.captured.delete();
    expected.delete();
  endtask

  task automatic run_entry(input draw_entry_t e, input int idx);
    draw_entry_t stray;
    int          n;
    string       what;
    what = $sformatf("draw %0d", idx);
    if (e.rand_colour) begin
      rng_state = xorshift32(rng_state);
      e.colour  = rng_state[15:0];
    end
    pulse_draw(e);
    if (e.accept) begin
      build_rect_bytes(e);
      n = expected.size();
      wait_ready(1'b0, 4, "after an accepted draw");
      if (e.poke && !aborted) begin
        // full screen strobe while the window bytes are still going out
        repeat (30) @(posedge hwclk);
        stray = '{x0: 0, x1: 239, y0: 0, y1: 319, colour: ~e.colour, rand_colour: 0,
                  accept: 0, poke: 0};
        pulse_draw(stray);
      end
      if (!aborted) begin
        wait_ready(1'b1, 200 + 16 * n, "after the last pixel byte");
      end
    end else begin
      // rejected, ready must stay up and the bus stays quiet
      for (n = 0; n < 40; n++) begin
        @(negedge hwclk);
        assert (ready === 1'b1) else begin
          $display("ready dropped after a draw that should have been rejected (%s)", what);
          failures++;
          break;
        end
      end
    end
    if (!aborted) begin
      compare_stream(what);
    end
  endtask

  initial begin
    hwclk      = 1'b0;
    reset      = 1'b1;
    draw       = 1'b0;
    x0         = '0;
    x1         = '0;
    y0         = '0;
    y1         = '0;
    colour     = '0;
    rng_state  = 32'h7cc2c4cc;
    mismatches = 0;
    failures   = 0;
    aborted    = 0;
    load_table();
    repeat (16) @(posedge hwclk);
    reset <= 1'b0;
    @(negedge hwclk);
    assert (ready === 1'b0) else begin
      $display("ready was high right after reset");
      failures++;
    end
    // wake-up commands only, then ready
    expect_byte(lcd_cmd_pkg::dcx_command, lcd_cmd_pkg::sw_reset);
    expect_byte(lcd_cmd_pkg::dcx_command, lcd_cmd_pkg::sleep_out);
    expect_byte(lcd_cmd_pkg::dcx_command, lcd_cmd_pkg::display_on);
    wait_ready(1'b1, 3000, "after power-up");
    if (!aborted) begin
      compare_stream("power-up");
    end
    foreach (draws[i]) begin
      if (aborted) break;
      run_entry(draws[i], i);
    end
    $display("errors: %0d mismatches, %0d other failures, %0d bus protocol errors",
             mismatches, failures, i_monitor.protocol_errors);
    if (mismatches == 0 && failures == 0 && i_monitor.protocol_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/lcd_cmd_pkg.sv
hw/lcd_geom_pkg.sv
hw/lcd_tick_gen.sv
hw/lcd_bus_writer.sv
hw/lcd_pixel_source.sv
hw/lcd_sequencer.sv
hw/lcd_display_top.sv
testbench/lcd_bus_monitor.sv
testbench/tb_lcd_display.sv

// ==== Bender.yml ====
package:
  name: lcd_display

sources:
  - target: rtl
    files:
      - hw/lcd_cmd_pkg.sv
      - hw/lcd_geom_pkg.sv
      - hw/lcd_tick_gen.sv
      - hw/lcd_bus_writer.sv
      - hw/lcd_pixel_source.sv
      - hw/lcd_sequencer.sv
      - hw/lcd_display_top.sv
  - target: test
    files:
      - testbench/lcd_bus_monitor.sv
      - testbench/tb_lcd_display.sv
